// File: key_extract_config.svh
`ifndef KEY_EXTRACT_CONFIG_SVH
`define KEY_EXTRACT_CONFIG_SVH

// packet header vector and its containers
`define KE_PHV_W      1124
`define KE_CONT_NUM   8
`define KE_C6_W       48
`define KE_C4_W       32
`define KE_C2_W       16
`define KE_IDX_W      3

// key is 2x6B + 2x4B + 2x2B followed by 5 predicate bits
`define KE_KEY_W      197

// offset table holds six 3-bit container indices per entry
`define KE_OFF_W      18
`define KE_TBL_DEPTH  16
`define KE_TBL_AW     4

// comparator words sit below the containers, stage 0 on top
`define KE_COMOP_BASE 355
`define KE_COMOP_W    20
`define KE_OPND_W     8

// vlan id in the metadata, bits [7:4] select the tenant entry
`define KE_VLAN_HI    140
`define KE_VLAN_LO    129

// valid stage numbers are 0 to 4
`define KE_STAGE_ID   0

`define KE_WB_DW      32

`endif

// File: key_extract_pkg.sv
`include "key_extract_config.svh"

package key_extract_pkg;

    // full header vector
    typedef logic [`KE_PHV_W-1:0] phv_t;

    // containers of 6, 4 and 2 bytes
    typedef logic [`KE_C6_W-1:0] cont6_t;
    typedef logic [`KE_C4_W-1:0] cont4_t;
    typedef logic [`KE_C2_W-1:0] cont2_t;

    typedef logic [`KE_IDX_W-1:0] cont_idx_t;

    typedef logic [`KE_KEY_W-1:0] key_t;

    // |6B|6B|4B|4B|2B|2B| from msb down
    typedef logic [`KE_OFF_W-1:0] key_off_t;

    typedef logic [`KE_TBL_AW-1:0] tbl_addr_t;

    // comparator operation word of one stage
    typedef logic [`KE_COMOP_W-1:0] com_op_t;
    typedef logic [`KE_OPND_W-1:0] operand_t;

    typedef logic [`KE_WB_DW-1:0] wb_dat_t;

    // wishbone slave handshake
    typedef enum logic [0:0] {
        WB_IDLE,
        WB_ACK
    } wb_state_t;

endpackage

// File: key_extract_ctrl.sv
module key_extract_ctrl (
    input  logic axis_clk,
    input  logic aresetn,
    input  logic phv_valid_in,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    output logic wb_ack,
    output logic tbl_wr_en,
    output logic s1_valid,
    output logic phv_valid_out
);

    import key_extract_pkg::*;

    wb_state_t state;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state         <= WB_IDLE;
            s1_valid      <= 1'b0;
            phv_valid_out <= 1'b0;
        end else begin
            // valid follows the phv through both register stages
            s1_valid      <= phv_valid_in;
            phv_valid_out <= s1_valid;

            case (state)
                WB_IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        state <= WB_ACK;
                    end
                end
                default: begin
                    state <= WB_IDLE;
                end
            endcase
        end
    end

    // single-cycle ack, the table is written on the ack edge
    assign wb_ack    = (state == WB_ACK);
    assign tbl_wr_en = wb_ack && wb_we;

    // master keeps the cycle open until it sees the ack
    a_ack_in_cycle: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        wb_ack |-> (wb_cyc && wb_stb)
    );

    a_ack_one_cycle: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        wb_ack |=> !wb_ack
    );

endmodule

// File: phv_container_regs.sv
`include "key_extract_config.svh"

module phv_container_regs (
    input  logic                      axis_clk,
    input  key_extract_pkg::phv_t     phv_in,
    output key_extract_pkg::phv_t     s1_phv,
    output key_extract_pkg::cont6_t   c6 [`KE_CONT_NUM],
    output key_extract_pkg::cont4_t   c4 [`KE_CONT_NUM],
    output key_extract_pkg::cont2_t   c2 [`KE_CONT_NUM],
    output key_extract_pkg::com_op_t  com_op
);

    // top bit of each container group
    localparam int C6_TOP = `KE_PHV_W - 1;
    localparam int C4_TOP = C6_TOP - `KE_CONT_NUM * `KE_C6_W;
    localparam int C2_TOP = C4_TOP - `KE_CONT_NUM * `KE_C4_W;

    // each stage reads its own 20-bit word, lower stages sit lower
    localparam int COMOP_TOP = `KE_COMOP_BASE - `KE_COMOP_W * `KE_STAGE_ID;

    always_ff @(posedge axis_clk) begin
        s1_phv <= phv_in;
        com_op <= phv_in[COMOP_TOP -: `KE_COMOP_W];

        // container 7 is the highest slice of its group
        for (int i = 0; i < `KE_CONT_NUM; i++) begin
            c6[i] <= phv_in[C6_TOP - (`KE_CONT_NUM - 1 - i) * `KE_C6_W -: `KE_C6_W];
            c4[i] <= phv_in[C4_TOP - (`KE_CONT_NUM - 1 - i) * `KE_C4_W -: `KE_C4_W];
            c2[i] <= phv_in[C2_TOP - (`KE_CONT_NUM - 1 - i) * `KE_C2_W -: `KE_C2_W];
        end
    end

endmodule

// File: key_offset_table.sv
`include "key_extract_config.svh"

module key_offset_table (
    input  logic                        axis_clk,
    input  logic                        tbl_wr_en,
    input  key_extract_pkg::tbl_addr_t  wb_adr,
    input  key_extract_pkg::wb_dat_t    wb_dat_w,
    input  key_extract_pkg::phv_t       phv_in,
    output key_extract_pkg::key_off_t   off_entry
);

    import key_extract_pkg::*;

    key_off_t  mem [`KE_TBL_DEPTH];
    logic [`KE_VLAN_HI-`KE_VLAN_LO:0] vlan_id;
    tbl_addr_t rd_addr;

    // tenant entry is picked by vlan id bits [7:4]
    assign vlan_id = phv_in[`KE_VLAN_HI:`KE_VLAN_LO];
    assign rd_addr = vlan_id[7:4];

    // a read on the write edge still returns the old entry
    always_ff @(posedge axis_clk) begin
        if (tbl_wr_en) begin
            mem[wb_adr] <= wb_dat_w[`KE_OFF_W-1:0];
        end
        off_entry <= mem[rd_addr];
    end

endmodule

// File: predicate_unit.sv
`include "key_extract_config.svh"

module predicate_unit (
    input  key_extract_pkg::cont6_t   c6 [`KE_CONT_NUM],
    input  key_extract_pkg::cont4_t   c4 [`KE_CONT_NUM],
    input  key_extract_pkg::cont2_t   c2 [`KE_CONT_NUM],
    input  key_extract_pkg::com_op_t  com_op,
    output logic                      pred_bit
);

    import key_extract_pkg::*;

    operand_t opnd_1;
    operand_t opnd_2;

    // immediate or the low byte of a container, size code 11 reads as zero
    function automatic operand_t pick_operand(
        input logic      imm_sel,
        input operand_t  imm,
        input logic [1:0] size,
        input cont_idx_t idx
    );
        operand_t res;
        res = '0;
        if (imm_sel) begin
            res = imm;
        end else begin
            case (size)
                2'b10:   res = c6[idx][`KE_OPND_W-1:0];
                2'b01:   res = c4[idx][`KE_OPND_W-1:0];
                2'b00:   res = c2[idx][`KE_OPND_W-1:0];
                default: res = '0;
            endcase
        end
        return res;
    endfunction

    always_comb begin
        opnd_1 = pick_operand(com_op[17], com_op[16:9], com_op[13:12], com_op[11:9]);
        opnd_2 = pick_operand(com_op[8], com_op[7:0], com_op[4:3], com_op[2:0]);

        // opcode in the top two bits
        case (com_op[19:18])
            2'b00:   pred_bit = (opnd_1 > opnd_2);
            2'b01:   pred_bit = (opnd_1 >= opnd_2);
            2'b10:   pred_bit = (opnd_1 == opnd_2);
            default: pred_bit = 1'b1;
        endcase
    end

endmodule

// File: key_builder.sv
`include "key_extract_config.svh"

module key_builder (
    input  logic                       axis_clk,
    input  logic                       aresetn,
    input  logic                       s1_valid,
    input  key_extract_pkg::phv_t      s1_phv,
    input  key_extract_pkg::cont6_t    c6 [`KE_CONT_NUM],
    input  key_extract_pkg::cont4_t    c4 [`KE_CONT_NUM],
    input  key_extract_pkg::cont2_t    c2 [`KE_CONT_NUM],
    input  key_extract_pkg::key_off_t  off_entry,
    input  logic                       pred_bit,
    output key_extract_pkg::phv_t      phv_out,
    output key_extract_pkg::key_t      key_out
);

    import key_extract_pkg::*;

    localparam int K6_TOP   = `KE_KEY_W - 1;
    localparam int K4_TOP   = K6_TOP - 2 * `KE_C6_W;
    localparam int K2_TOP   = K4_TOP - 2 * `KE_C4_W;
    localparam int PRED_POS = 4 - `KE_STAGE_ID;

    cont_idx_t idx [6];
    key_t      key_nxt;

    always_comb begin
        // index fields from msb: 6B, 6B, 4B, 4B, 2B, 2B
        for (int f = 0; f < 6; f++) begin
            idx[f] = off_entry[`KE_OFF_W - 1 - f * `KE_IDX_W -: `KE_IDX_W];
        end

        key_nxt = '0;
        key_nxt[K6_TOP -: `KE_C6_W]            = c6[idx[0]];
        key_nxt[K6_TOP - `KE_C6_W -: `KE_C6_W] = c6[idx[1]];
        key_nxt[K4_TOP -: `KE_C4_W]            = c4[idx[2]];
        key_nxt[K4_TOP - `KE_C4_W -: `KE_C4_W] = c4[idx[3]];
        key_nxt[K2_TOP -: `KE_C2_W]            = c2[idx[4]];
        key_nxt[K2_TOP - `KE_C2_W -: `KE_C2_W] = c2[idx[5]];
        // only this stage's predicate slot is filled
        key_nxt[PRED_POS] = pred_bit;
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            phv_out <= '0;
            key_out <= '0;
        end else if (s1_valid) begin
            phv_out <= s1_phv;
            key_out <= key_nxt;
        end
    end

    // s1_valid one cycle back is phv_valid_out now
    a_key_known: assert property (
        @(posedge axis_clk) disable iff (!aresetn)
        s1_valid |=> !$isunknown(key_out)
    );

endmodule

// File: key_extract_top.sv
`include "key_extract_config.svh"

module key_extract_top (
    input  logic                        axis_clk,
    input  logic                        aresetn,
    input  key_extract_pkg::phv_t       phv_in,
    input  logic                        phv_valid_in,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  key_extract_pkg::tbl_addr_t  wb_adr,
    input  key_extract_pkg::wb_dat_t    wb_dat_w,
    output logic                        wb_ack,
    output key_extract_pkg::phv_t       phv_out,
    output logic                        phv_valid_out,
    output key_extract_pkg::key_t       key_out
);

    import key_extract_pkg::*;

    logic     tbl_wr_en;
    logic     s1_valid;
    phv_t     s1_phv;
    cont6_t   c6 [`KE_CONT_NUM];
    cont4_t   c4 [`KE_CONT_NUM];
    cont2_t   c2 [`KE_CONT_NUM];
    com_op_t  com_op;
    key_off_t off_entry;
    logic     pred_bit;

    key_extract_ctrl i_ctrl (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .phv_valid_in  (phv_valid_in),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_ack        (wb_ack),
        .tbl_wr_en     (tbl_wr_en),
        .s1_valid      (s1_valid),
        .phv_valid_out (phv_valid_out)
    );

    phv_container_regs i_regs (
        .axis_clk (axis_clk),
        .phv_in   (phv_in),
        .s1_phv   (s1_phv),
        .c6       (c6),
        .c4       (c4),
        .c2       (c2),
        .com_op   (com_op)
    );

    key_offset_table i_table (
        .axis_clk  (axis_clk),
        .tbl_wr_en (tbl_wr_en),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .phv_in    (phv_in),
        .off_entry (off_entry)
    );

    predicate_unit i_pred (
        .c6       (c6),
        .c4       (c4),
        .c2       (c2),
        .com_op   (com_op),
        .pred_bit (pred_bit)
    );

    key_builder i_builder (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .s1_valid  (s1_valid),
        .s1_phv    (s1_phv),
        .c6        (c6),
        .c4        (c4),
        .c2        (c2),
        .off_entry (off_entry),
        .pred_bit  (pred_bit),
        .phv_out   (phv_out),
        .key_out   (key_out)
    );

endmodule

// File: key_extract_checker.sv
`include "key_extract_config.svh"

module key_extract_checker (
    input  logic                        axis_clk,
    input  logic                        aresetn,
    input  key_extract_pkg::phv_t       phv_in,
    input  logic                        phv_valid_in,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  key_extract_pkg::tbl_addr_t  wb_adr,
    input  key_extract_pkg::wb_dat_t    wb_dat_w,
    input  logic                        wb_ack,
    input  key_extract_pkg::phv_t       phv_out,
    input  logic                        phv_valid_out,
    input  key_extract_pkg::key_t       key_out,
    output int                          errors,
    output int                          checks,
    output int                          pending
);

    import key_extract_pkg::*;

    // container groups counted up from bit 0, the 2-byte group lowest
    localparam int C6_LO = `KE_PHV_W - `KE_CONT_NUM * `KE_C6_W;
    localparam int C4_LO = C6_LO - `KE_CONT_NUM * `KE_C4_W;
    localparam int C2_LO = C4_LO - `KE_CONT_NUM * `KE_C2_W;
    localparam int OP_LO = `KE_COMOP_BASE - `KE_COMOP_W * (`KE_STAGE_ID + 1) + 1;

    key_off_t  shadow [`KE_TBL_DEPTH];
    phv_t      exp_phv [$];
    key_t      exp_key [$];
    int        exp_edge [$];
    int        edge_cnt;
    key_t      last_key;
    logic      ack_d;
    logic      idle_checked;
    tbl_addr_t rd_addr;

    function automatic operand_t operand_of(input phv_t p, input logic imm_sel,
                                            input operand_t imm, input logic [1:0] size,
                                            input cont_idx_t idx);
        if (imm_sel) return imm;
        case (size)
            2'b10:   return p[C6_LO + `KE_C6_W * int'(idx) +: `KE_OPND_W];
            2'b01:   return p[C4_LO + `KE_C4_W * int'(idx) +: `KE_OPND_W];
            2'b00:   return p[C2_LO + `KE_C2_W * int'(idx) +: `KE_OPND_W];
            default: return '0;
        endcase
    endfunction

    function automatic logic pred_of(input phv_t p);
        com_op_t  op;
        operand_t a;
        operand_t b;
        op = p[OP_LO +: `KE_COMOP_W];
        a  = operand_of(p, op[17], op[16:9], op[13:12], op[11:9]);
        b  = operand_of(p, op[8], op[7:0], op[4:3], op[2:0]);
        case (op[19:18])
            2'b00:   return a > b;
            2'b01:   return a >= b;
            2'b10:   return a == b;
            default: return 1'b1;
        endcase
    endfunction

    // slots from the top: 6B, 6B, 4B, 4B, 2B, 2B, then the predicate bits
    function automatic key_t key_of(input phv_t p, input key_off_t e);
        logic [4:0] preds;
        preds = '0;
        preds[4 - `KE_STAGE_ID] = pred_of(p);
        return {p[C6_LO + `KE_C6_W * int'(e[17:15]) +: `KE_C6_W],
                p[C6_LO + `KE_C6_W * int'(e[14:12]) +: `KE_C6_W],
                p[C4_LO + `KE_C4_W * int'(e[11:9]) +: `KE_C4_W],
                p[C4_LO + `KE_C4_W * int'(e[8:6]) +: `KE_C4_W],
                p[C2_LO + `KE_C2_W * int'(e[5:3]) +: `KE_C2_W],
                p[C2_LO + `KE_C2_W * int'(e[2:0]) +: `KE_C2_W], preds};
    endfunction

    task automatic compare(input string name, input phv_t got, input phv_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    // all values are taken before the edge updates the DUT
    always @(posedge axis_clk) begin
        if (!aresetn) begin
            errors       = 0;
            checks       = 0;
            pending      = 0;
            edge_cnt     = 0;
            ack_d        = 1'b0;
            last_key     = '0;
            idle_checked = 1'b0;
        end else begin
            edge_cnt++;
            if (!idle_checked) begin
                idle_checked = 1'b1;
                compare("phv_valid_out", phv_t'(phv_valid_out), '0);
                compare("wb_ack", phv_t'(wb_ack), '0);
                compare("key_out", phv_t'(key_out), '0);
                compare("phv_out", phv_out, '0);
            end
            if (wb_ack && !(wb_cyc && wb_stb)) begin
                errors++;
                $display("wb_ack was raised outside a bus cycle at %0t", $time);
            end
            if (wb_ack && ack_d) begin
                errors++;
                $display("wb_ack stayed high for two cycles at %0t", $time);
            end
            ack_d = wb_ack;

            if (phv_valid_out) begin
                if (exp_phv.size() == 0) begin
                    errors++;
                    $display("phv_valid_out pulsed with no PHV outstanding at %0t", $time);
                end else begin
                    compare("phv_out", phv_out, exp_phv.pop_front());
                    compare("key_out", phv_t'(key_out), phv_t'(exp_key.pop_front()));
                    if (exp_edge.pop_front() != edge_cnt - 2) begin
                        errors++;
                        $display("PHV came out with the wrong latency at %0t", $time);
                    end
                end
                last_key = key_out;
            end else begin
                compare("key_out", phv_t'(key_out), phv_t'(last_key));
            end

            // a PHV on the write edge still reads the old entry
            if (phv_valid_in) begin
                rd_addr = phv_in[`KE_VLAN_LO + 7 : `KE_VLAN_LO + 4];
                exp_phv.push_back(phv_in);
                exp_key.push_back(key_of(phv_in, shadow[rd_addr]));
                exp_edge.push_back(edge_cnt);
            end
            if (wb_ack && wb_we) begin
                shadow[wb_adr] = wb_dat_w[`KE_OFF_W-1:0];
            end
            pending = exp_phv.size();
        end
    end

endmodule

// File: tb_key_extract.sv
`include "key_extract_config.svh"

module tb_key_extract;

    import key_extract_pkg::*;

    localparam int RST_CYCLES = 10;
    localparam int BURST_LEN  = 40;
    localparam int REWRITES   = 4;
    // about three clocks per bus cycle plus idle and drain time
    localparam int PLAN_CYCLES = RST_CYCLES + 3 * (`KE_TBL_DEPTH + REWRITES + 1)
                                 + 2 * BURST_LEN + 20;
    localparam int MAX_CYCLES  = 4 * PLAN_CYCLES;
    localparam int OP_LO = `KE_COMOP_BASE - `KE_COMOP_W * (`KE_STAGE_ID + 1) + 1;

    logic      axis_clk;
    logic      aresetn;
    logic      phv_valid_in;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    logic      wb_ack;
    logic      phv_valid_out;
    phv_t      phv_in;
    phv_t      phv_out;
    key_t      key_out;
    tbl_addr_t wb_adr;
    wb_dat_t   wb_dat_w;
    int        errors;
    int        checks;
    int        pending;
    int        cycles = 0;
    integer    seed;

    key_extract_top i_dut (.*);

    key_extract_checker i_checker (.*);

    initial axis_clk = 1'b0;
    always #10 axis_clk = ~axis_clk;

    always @(posedge axis_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // master holds the cycle until the ack has been taken
    task automatic bus_cycle(input tbl_addr_t adr, input logic we);
        @(negedge axis_clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = $random(seed);
        do begin
            @(negedge axis_clk);
        end while (!wb_ack);
        @(negedge axis_clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic drive_phv(input logic valid, input tbl_addr_t tenant);
        phv_t p;
        for (int k = 0; k < (`KE_PHV_W + 31) / 32; k++) begin
            p = {p[`KE_PHV_W-33:0], 32'($random(seed))};
        end
        // vlan id bits [7:4] pick the table entry
        p[`KE_VLAN_LO + 4 +: `KE_TBL_AW] = tenant;
        // now and then compare an immediate with itself so equality holds
        if (($random(seed) & 7) == 0) begin
            p[OP_LO + 17] = 1'b1;
            p[OP_LO + 8]  = 1'b1;
            p[OP_LO +: 8] = p[OP_LO + 9 +: 8];
        end
        phv_in       = p;
        phv_valid_in = valid;
    endtask

    // mostly back to back with random gaps
    task automatic run_burst(input int n);
        logic      valid;
        tbl_addr_t tenant;
        tenant = '0;
        for (int i = 0; i < n; i++) begin
            @(negedge axis_clk);
            valid = ($random(seed) & 3) != 0;
            drive_phv(valid, tenant);
            // each valid PHV moves on to the next entry so all of them are read
            if (valid) begin
                tenant++;
            end
        end
        @(negedge axis_clk);
        phv_valid_in = 1'b0;
    endtask

    initial begin
        seed         = 32'h2fc2;
        aresetn      = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        repeat (RST_CYCLES) @(negedge axis_clk);
        aresetn = 1'b1;
        repeat (3) @(negedge axis_clk);
        for (int a = 0; a < `KE_TBL_DEPTH; a++) begin
            bus_cycle(tbl_addr_t'(a), 1'b1);
        end
        run_burst(BURST_LEN);
        for (int r = 0; r < REWRITES; r++) begin
            bus_cycle(tbl_addr_t'($random(seed)), 1'b1);
        end
        // cycle with wb_we low is acked and leaves the table untouched
        bus_cycle(tbl_addr_t'($random(seed)), 1'b0);
        run_burst(BURST_LEN);
        while (pending != 0) @(negedge axis_clk);
        repeat (4) @(negedge axis_clk);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0 && checks > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
key_extract_pkg.sv
key_extract_ctrl.sv
phv_container_regs.sv
key_offset_table.sv
predicate_unit.sv
key_builder.sv
key_extract_top.sv
key_extract_checker.sv
tb_key_extract.sv

// File: Makefile
TOP := tb_key_extract

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module key_extract_top
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
